/* rename_unit.f */
+incdir+.
logic/rename_pkg.sv
logic/free_list.sv
logic/spec_map_table.sv
logic/arch_map_table.sv
logic/rename_unit.sv
test/tb_rename_unit.sv

/* run.sh */
#!/bin/sh
# Build the rename unit testbench with Verilator, run it and look for the pass line
verilator --binary --timing -Wno-fatal -f rename_unit.f --top-module tb_rename_unit \
  -o sim_rename_unit &&
  result=$(./obj_dir/sim_rename_unit) &&
  echo "$result" &&
  echo "$result" | grep -qx "No errors" ||
  { echo "Simulation failed"; exit 1; }
echo "Simulation passed"

/* test/tb_rename_unit.sv */
// ==================
// Rename unit testbench
// Directed tests against a model of both maps and the free queue
// ==================

`timescale 1ns/1ns

`include "rename_defines.svh"

module tb_rename_unit
  import rename_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  // Rough cycle budget, reset then the five tests in order
  localparam int RUN_CYCLES   = RESET_CYCLES + 10 + 10 + 80 + 100 + 60;

  logic                            clk;
  logic                            rst_n;
  logic                            flush_i;
  logic                            rename_ready_o;
  rename_req_t [`DECODE_WIDTH-1:0] rename_req_i;
  rename_rsp_t [`DECODE_WIDTH-1:0] rename_rsp_o;
  commit_t     [`COMMIT_WIDTH-1:0] commit_i;

  // ==================
  // Reference model
  // ==================

  preg_t       smap [`ARCH_REG_NUM];
  preg_t       cmap [`ARCH_REG_NUM];
  preg_t       fq [FL_DEPTH];
  // Free queue pointers, never wrapped, indexed modulo depth
  int          sh;
  int          ch;
  int          tl;
  // Renamed but not yet committed, oldest first
  commit_t     inflight [$];
  int          preg_errors;
  int          flag_errors;
  logic [31:0] lfsr_q;

  rename_unit uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .rename_req_i   (rename_req_i),
    .rename_ready_o (rename_ready_o),
    .rename_rsp_o   (rename_rsp_o),
    .commit_i       (commit_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #((RUN_CYCLES + 20) * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Errors found");
    $finish;
  end

  // ==================
  // Helpers
  // ==================

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic areg_t rand_areg();
    areg_t a;
    for (int i = 0; i < AREG_W; i++) begin
      a[i] = next_bit();
    end
    return a;
  endfunction

  // Valid request with a destination, all registers random
  function automatic rename_req_t random_req();
    rename_req_t r;
    r.valid     = 1'b1;
    r.dst_valid = 1'b1;
    r.dst_areg  = rand_areg();
    r.src1_areg = rand_areg();
    r.src2_areg = rand_areg();
    return r;
  endfunction

  task automatic check_preg(input string name, input preg_t got, input preg_t exp);
    if (got !== exp) begin
      preg_errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_ready();
    check_valid("rename_ready_o", rename_ready_o, (tl - sh) >= `DECODE_WIDTH);
  endtask

  // One group in, response checked a cycle later
  task automatic rename_group(input rename_req_t r0, input rename_req_t r1);
    rename_req_t req [`DECODE_WIDTH];
    rename_rsp_t exp [`DECODE_WIDTH];
    commit_t     c;
    req[0] = r0;
    req[1] = r1;
    // Slots in order, sources read before own destination lands
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      exp[i] = '0;
      if (req[i].valid) begin
        exp[i].valid     = 1'b1;
        exp[i].dst_valid = req[i].dst_valid;
        exp[i].src1_preg = smap[req[i].src1_areg];
        exp[i].src2_preg = smap[req[i].src2_areg];
        exp[i].old_preg  = smap[req[i].dst_areg];
        if (req[i].dst_valid) begin
          exp[i].dst_preg = fq[sh % FL_DEPTH];
          sh++;
          smap[req[i].dst_areg] = exp[i].dst_preg;
          c = '{1'b1, 1'b1, req[i].dst_areg, exp[i].dst_preg};
          inflight.push_back(c);
        end
      end
    end
    @(posedge clk);
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      rename_req_i[i] <= req[i];
    end
    @(posedge clk);
    rename_req_i <= '0;
    @(negedge clk);
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      check_valid($sformatf("rsp[%0d].valid", i), rename_rsp_o[i].valid, exp[i].valid);
      if (exp[i].valid) begin
        check_preg($sformatf("rsp[%0d].src1_preg", i), rename_rsp_o[i].src1_preg,
                   exp[i].src1_preg);
        check_preg($sformatf("rsp[%0d].src2_preg", i), rename_rsp_o[i].src2_preg,
                   exp[i].src2_preg);
        check_valid($sformatf("rsp[%0d].dst_valid", i), rename_rsp_o[i].dst_valid,
                    exp[i].dst_valid);
      end
      if (exp[i].dst_valid) begin
        check_preg($sformatf("rsp[%0d].dst_preg", i), rename_rsp_o[i].dst_preg,
                   exp[i].dst_preg);
        check_preg($sformatf("rsp[%0d].old_preg", i), rename_rsp_o[i].old_preg,
                   exp[i].old_preg);
      end
    end
    check_ready();
  endtask

  task automatic rename_random();
    rename_req_t r0;
    rename_req_t r1;
    r0 = random_req();
    r1 = random_req();
    rename_group(r0, r1);
  endtask

  // Oldest n renames retire, replaced registers go to the queue tail
  task automatic commit_group(input int n);
    commit_t cg [`COMMIT_WIDTH];
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      cg[i] = '0;
      if (i < n) begin
        cg[i] = inflight.pop_front();
        fq[tl % FL_DEPTH] = cmap[cg[i].areg];
        tl++;
        ch++;
        cmap[cg[i].areg] = cg[i].preg;
      end
    end
    @(posedge clk);
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      commit_i[i] <= cg[i];
    end
    @(posedge clk);
    commit_i <= '0;
    @(negedge clk);
    check_ready();
  endtask

  task automatic commit_all();
    while (inflight.size() > 0) begin
      commit_group(inflight.size() >= `COMMIT_WIDTH ? `COMMIT_WIDTH : inflight.size());
    end
  endtask

  task automatic flush_pipe();
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    // Committed state becomes the speculative state
    for (int i = 0; i < `ARCH_REG_NUM; i++) begin
      smap[i] = cmap[i];
    end
    sh = ch;
    inflight.delete();
    @(negedge clk);
    check_ready();
  endtask

  // ==================
  // Tests
  // ==================

  task automatic test_reset();
    rename_req_t r0;
    rename_req_t r1;
    @(negedge clk);
    check_valid("rename_ready_o", rename_ready_o, 1'b1);
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      check_valid($sformatf("rsp[%0d].valid", i), rename_rsp_o[i].valid, 1'b0);
    end
    // Distinct destinations so old_preg stays the identity
    r0 = random_req();
    r1 = random_req();
    r0.dst_areg = areg_t'(5);
    r1.dst_areg = areg_t'(6);
    rename_group(r0, r1);
    check_preg("rsp[0].dst_preg", rename_rsp_o[0].dst_preg, preg_t'(`ARCH_REG_NUM));
    check_preg("rsp[1].dst_preg", rename_rsp_o[1].dst_preg, preg_t'(`ARCH_REG_NUM + 1));
    // Response lasts one cycle only
    @(negedge clk);
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      check_valid($sformatf("rsp[%0d].valid", i), rename_rsp_o[i].valid, 1'b0);
    end
  endtask

  task automatic test_bypass();
    rename_req_t r0;
    rename_req_t r1;
    rename_req_t r2;
    r0 = random_req();
    r1 = random_req();
    // Slot 1 reads what slot 0 writes
    r1.src1_areg = r0.dst_areg;
    rename_group(r0, r1);
    // Next group sees both new mappings
    r2 = random_req();
    r2.src1_areg = r0.dst_areg;
    r2.src2_areg = r1.dst_areg;
    rename_group(r2, '0);
  endtask

  task automatic test_exhaust();
    while ((tl - sh) >= `DECODE_WIDTH) begin
      rename_random();
    end
    check_valid("rename_ready_o", rename_ready_o, 1'b0);
    commit_group(`COMMIT_WIDTH);
    check_valid("rename_ready_o", rename_ready_o, 1'b1);
  endtask

  task automatic test_reuse();
    commit_all();
    // Allocation wraps into the freed registers
    repeat (8) rename_random();
  endtask

  task automatic test_flush();
    preg_t squashed [$];
    repeat (4) rename_random();
    foreach (inflight[i]) begin
      squashed.push_back(inflight[i].preg);
    end
    flush_pipe();
    repeat (4) begin
      rename_random();
      for (int i = 0; i < `DECODE_WIDTH; i++) begin
        check_preg($sformatf("reused rsp[%0d].dst_preg", i), rename_rsp_o[i].dst_preg,
                   squashed.pop_front());
      end
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    flush_i      = 1'b0;
    rename_req_i = '0;
    commit_i     = '0;
    lfsr_q       = 32'hf691_f55a;
    preg_errors  = 0;
    flag_errors  = 0;
    // Model reset state
    for (int i = 0; i < `ARCH_REG_NUM; i++) begin
      smap[i] = preg_t'(i);
      cmap[i] = preg_t'(i);
    end
    for (int i = 0; i < FL_DEPTH; i++) begin
      fq[i] = preg_t'(`ARCH_REG_NUM + i);
    end
    sh = 0;
    ch = 0;
    tl = FL_DEPTH;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_bypass();
    test_exhaust();
    test_reuse();
    test_flush();
    $display("Check summary: %0d preg errors, %0d flag errors", preg_errors, flag_errors);
    if (preg_errors + flag_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* logic/rename_unit.sv */
// ==================
// Rename unit
// Free list with speculative and committed maps
// ==================

`timescale 1ns/1ns

`include "rename_defines.svh"

module rename_unit
  import rename_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 flush_i,
  input  rename_req_t [`DECODE_WIDTH-1:0]      rename_req_i,
  output logic                                 rename_ready_o,
  output rename_rsp_t [`DECODE_WIDTH-1:0]      rename_rsp_o,
  input  commit_t     [`COMMIT_WIDTH-1:0]      commit_i
);

  // ==================
  // Internal nets
  // ==================

  // New destinations for this group
  preg_t   [`DECODE_WIDTH-1:0] alloc_preg;
  // Registers released by commit
  commit_t [`COMMIT_WIDTH-1:0] free_preg;
  // Committed map for flush restore
  preg_t   [`ARCH_REG_NUM-1:0] arch_map;

  // Allocation and release
  free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .alloc_req_i  (rename_req_i),
    .commit_i     (commit_i),
    .free_i       (free_preg),
    .alloc_preg_o (alloc_preg),
    .ready_o      (rename_ready_o)
  );

  // Speculative renaming
  spec_map_table u_spec_map_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .req_i        (rename_req_i),
    .alloc_preg_i (alloc_preg),
    .arch_map_i   (arch_map),
    .rsp_o        (rename_rsp_o)
  );

  // Committed state
  arch_map_table u_arch_map_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .commit_i     (commit_i),
    .arch_map_o   (arch_map),
    .free_o       (free_preg)
  );

endmodule

/* logic/arch_map_table.sv */
// ==================
// Architectural map table
// Committed mapping, returns replaced registers
// ==================

`timescale 1ns/1ns

`include "rename_defines.svh"

module arch_map_table
  import rename_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  commit_t [`COMMIT_WIDTH-1:0]     commit_i,
  output preg_t   [`ARCH_REG_NUM-1:0]     arch_map_o,
  output commit_t [`COMMIT_WIDTH-1:0]     free_o
);

  preg_t [`ARCH_REG_NUM-1:0] map_q;

  // ==================
  // Replaced registers
  // ==================

  always_comb begin
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      free_o[i].valid     = commit_i[i].valid;
      free_o[i].dst_valid = commit_i[i].dst_valid;
      free_o[i].areg      = commit_i[i].areg;
      free_o[i].preg      = map_q[commit_i[i].areg];
      // Earlier slot in the group already replaced this mapping
      for (int j = 0; j < i; j++) begin
        if (commit_i[j].valid && commit_i[j].dst_valid &&
            commit_i[j].areg == commit_i[i].areg) begin
          free_o[i].preg = commit_i[j].preg;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `ARCH_REG_NUM; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else begin
      for (int i = 0; i < `COMMIT_WIDTH; i++) begin
        if (commit_i[i].valid && commit_i[i].dst_valid) begin
          map_q[commit_i[i].areg] <= commit_i[i].preg;
        end
      end
    end
  end

  assign arch_map_o = map_q;

endmodule

/* logic/spec_map_table.sv */
// ==================
// Speculative map table
// Source lookup with intra-group bypass
// Restored from the committed map on flush
// ==================

`timescale 1ns/1ns

`include "rename_defines.svh"

module spec_map_table
  import rename_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 flush_i,
  input  rename_req_t [`DECODE_WIDTH-1:0]      req_i,
  input  preg_t       [`DECODE_WIDTH-1:0]      alloc_preg_i,
  input  preg_t       [`ARCH_REG_NUM-1:0]      arch_map_i,
  output rename_rsp_t [`DECODE_WIDTH-1:0]      rsp_o
);

  // ==================
  // State
  // ==================

  preg_t       [`ARCH_REG_NUM-1:0] map_q;
  rename_rsp_t [`DECODE_WIDTH-1:0] rsp_n;
  rename_rsp_t [`DECODE_WIDTH-1:0] rsp_q;

  // ==================
  // Lookup
  // ==================

  always_comb begin
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      // Requests in a flush cycle are dropped
      rsp_n[i].valid     = req_i[i].valid && !flush_i;
      rsp_n[i].dst_valid = req_i[i].valid && req_i[i].dst_valid && !flush_i;
      rsp_n[i].dst_preg  = alloc_preg_i[i];
      // Mappings as of the start of the group
      rsp_n[i].old_preg  = map_q[req_i[i].dst_areg];
      rsp_n[i].src1_preg = map_q[req_i[i].src1_areg];
      rsp_n[i].src2_preg = map_q[req_i[i].src2_areg];
      // Earlier slots override, the nearest one last
      for (int j = 0; j < i; j++) begin
        if (req_i[j].valid && req_i[j].dst_valid) begin
          if (req_i[j].dst_areg == req_i[i].src1_areg) begin
            rsp_n[i].src1_preg = alloc_preg_i[j];
          end
          if (req_i[j].dst_areg == req_i[i].src2_areg) begin
            rsp_n[i].src2_preg = alloc_preg_i[j];
          end
          // Same destination twice, old value is the earlier new one
          if (req_i[j].dst_areg == req_i[i].dst_areg) begin
            rsp_n[i].old_preg = alloc_preg_i[j];
          end
        end
      end
    end
  end

  // ==================
  // Update
  // ==================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity mapping
      for (int i = 0; i < `ARCH_REG_NUM; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else if (flush_i) begin
      map_q <= arch_map_i;
    end else begin
      // Later slot lands last and wins
      for (int i = 0; i < `DECODE_WIDTH; i++) begin
        if (req_i[i].valid && req_i[i].dst_valid) begin
          map_q[req_i[i].dst_areg] <= alloc_preg_i[i];
        end
      end
    end
  end

  // Response is valid for one cycle after the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_n;
    end
  end

  assign rsp_o = rsp_q;

endmodule

/* logic/free_list.sv */
// ==================
// Free list
// Circular queue of free physical registers
// Speculative and committed heads, one tail
// ==================

`timescale 1ns/1ns

`include "rename_defines.svh"

module free_list
  import rename_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 flush_i,
  input  rename_req_t [`DECODE_WIDTH-1:0]      alloc_req_i,
  input  commit_t     [`COMMIT_WIDTH-1:0]      commit_i,
  input  commit_t     [`COMMIT_WIDTH-1:0]      free_i,
  output preg_t       [`DECODE_WIDTH-1:0]      alloc_preg_o,
  output logic                                 ready_o
);

  localparam int unsigned IDX_W = FL_PTR_W - 1;

  // ==================
  // State
  // ==================

  preg_t   queue_q [FL_DEPTH];
  fl_ptr_t spec_head_q;
  fl_ptr_t commit_head_q;
  fl_ptr_t tail_q;

  fl_ptr_t spec_head_n;
  fl_ptr_t commit_head_n;
  fl_ptr_t tail_n;
  // Read pointer walking across the group
  fl_ptr_t rd_ptr;
  fl_cnt_t free_cnt;

  logic [`COMMIT_WIDTH-1:0] wr_en;
  logic [IDX_W-1:0]         wr_idx [`COMMIT_WIDTH];

  // ==================
  // Allocation
  // ==================

  // Slots with a destination take entries in slot order
  always_comb begin
    rd_ptr = spec_head_q;
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      alloc_preg_o[i] = '0;
      if (alloc_req_i[i].valid && alloc_req_i[i].dst_valid) begin
        alloc_preg_o[i] = queue_q[rd_ptr[IDX_W-1:0]];
        rd_ptr          = rd_ptr + fl_ptr_t'(1);
      end
    end
  end

  // Flush rolls back to the committed head
  // Squashed registers are then handed out again in the same order
  always_comb begin
    spec_head_n = flush_i ? commit_head_q : rd_ptr;
  end

  // Committed head follows retired destinations
  always_comb begin
    commit_head_n = commit_head_q;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (commit_i[i].valid && commit_i[i].dst_valid) begin
        commit_head_n = commit_head_n + fl_ptr_t'(1);
      end
    end
  end

  // ==================
  // Release
  // ==================

  // Freed registers append at the tail in slot order
  always_comb begin
    tail_n = tail_q;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      wr_en[i]  = free_i[i].valid && free_i[i].dst_valid;
      wr_idx[i] = tail_n[IDX_W-1:0];
      if (wr_en[i]) begin
        tail_n = tail_n + fl_ptr_t'(1);
      end
    end
  end

  // Wrap bit makes the difference exact from 0 to FL_DEPTH
  assign free_cnt = tail_q - spec_head_q;
  // Room for a full decode group
  assign ready_o  = free_cnt >= fl_cnt_t'(`DECODE_WIDTH);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Registers above the identity map start out free
      for (int i = 0; i < FL_DEPTH; i++) begin
        queue_q[i] <= preg_t'(`ARCH_REG_NUM + i);
      end
      spec_head_q   <= '0;
      commit_head_q <= '0;
      tail_q        <= fl_ptr_t'(FL_DEPTH);
    end else begin
      for (int i = 0; i < `COMMIT_WIDTH; i++) begin
        if (wr_en[i]) begin
          queue_q[wr_idx[i]] <= free_i[i].preg;
        end
      end
      spec_head_q   <= spec_head_n;
      commit_head_q <= commit_head_n;
      tail_q        <= tail_n;
    end
  end

endmodule

/* logic/rename_pkg.sv */
// ==================
// Rename types
// Register indices, request, response and commit records
// ==================

`include "rename_defines.svh"

package rename_pkg;

  // Derived widths
  localparam int unsigned AREG_W   = $clog2(`ARCH_REG_NUM);
  localparam int unsigned PREG_W   = $clog2(`PHY_REG_NUM);
  // Registers not mapped at reset sit in the free queue
  localparam int unsigned FL_DEPTH = `PHY_REG_NUM - `ARCH_REG_NUM;
  // One extra bit for wrap detection
  localparam int unsigned FL_PTR_W = $clog2(FL_DEPTH) + 1;
  localparam int unsigned FL_CNT_W = $clog2(FL_DEPTH + 1);

  typedef logic [AREG_W-1:0]   areg_t;
  typedef logic [PREG_W-1:0]   preg_t;
  typedef logic [FL_PTR_W-1:0] fl_ptr_t;
  typedef logic [FL_CNT_W-1:0] fl_cnt_t;

  // One decoded instruction
  typedef struct packed {
    logic  valid;
    logic  dst_valid;
    areg_t dst_areg;
    areg_t src1_areg;
    areg_t src2_areg;
  } rename_req_t;

  // One renamed instruction
  typedef struct packed {
    logic  valid;
    logic  dst_valid;
    preg_t dst_preg;
    // Previous mapping of the destination
    preg_t old_preg;
    preg_t src1_preg;
    preg_t src2_preg;
  } rename_rsp_t;

  // One retired instruction, also reused for freed registers
  typedef struct packed {
    logic  valid;
    logic  dst_valid;
    areg_t areg;
    preg_t preg;
  } commit_t;

endpackage

/* rename_defines.svh */
// ==================
// Rename stage sizing
// Group widths and register file sizes
// ==================

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// ==================
// Group widths
// ==================

// Instructions renamed per cycle
`define DECODE_WIDTH 2
// Instructions retired per cycle
`define COMMIT_WIDTH 2

// ==================
// Register files
// ==================

// Architectural registers seen by software
`define ARCH_REG_NUM 32
// Physical registers behind the maps
`define PHY_REG_NUM 64

`endif
